// ==== dv/rename_core_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module rename_core_tb
    import rename_pkg::*;
();

    localparam int ACK_TIMEOUT = 200;  // Cycles, covers a full station of MULs

    logic             clock;
    logic             reset;
    logic             cyc;
    logic             stb;
    logic             we;
    logic [ADR_W-1:0] adr;
    data_t            wdata;
    data_t            rdata;
    logic             ack;

    data_t model [NUM_REGS];  // Register values in program order
    string current_test;
    int    error_count = 0;
    int    errors_at_start = 0;
    int    test_count = 0;
    int    check_count = 0;

    rename_core DUT (.clock, .reset, .cyc, .stb, .we, .adr, .wdata, .rdata, .ack);

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    function automatic data_t alu_model(alu_op_e op, data_t a, data_t b);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            default: return a * b;  // Low 32 bits of the product
        endcase
    endfunction

    task automatic compare_word(input string what, input data_t expected, input data_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED %s %s: expected %h, actual %h",
                     current_test, what, expected, actual);
        end
    endtask

    // Ack is sampled on falling edges, where it is stable
    task automatic wait_for_ack(input logic [ADR_W-1:0] addr);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clock);
            cycles++;
        end while (!ack && cycles < ACK_TIMEOUT);
        if (!ack) begin
            error_count++;
            $display("%s: the core gave no ack within %0d cycles for address %h",
                     current_test, ACK_TIMEOUT, addr);
        end
    endtask

    task automatic bus_write(input logic [ADR_W-1:0] addr, input data_t data);
        @(negedge clock);
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = 1'b1;
        adr   = addr;
        wdata = data;
        wait_for_ack(addr);
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
    endtask

    task automatic bus_read(input logic [ADR_W-1:0] addr, output data_t data);
        @(negedge clock);
        cyc = 1'b1;
        stb = 1'b1;
        we  = 1'b0;
        adr = addr;
        wait_for_ack(addr);
        data = rdata;
        cyc  = 1'b0;
        stb  = 1'b0;
    endtask

    task automatic write_reg(input int idx, input data_t value);
        bus_write(ADR_W'((1 << REG_SEL_BIT) | idx), value);
        model[idx] = value;
    endtask

    task automatic check_reg(input int idx);
        data_t value;
        bus_read(ADR_W'((1 << REG_SEL_BIT) | idx), value);
        compare_word($sformatf("r%0d", idx), model[idx], value);
    endtask

    task automatic issue(input alu_op_e op, input int rd, input int rs1, input int rs2);
        data_t word;
        word                  = '0;
        word[OP_MSB:OP_LSB]   = op;
        word[RD_MSB:RD_LSB]   = REG_IDX_W'(rd);
        word[RS1_MSB:RS1_LSB] = REG_IDX_W'(rs1);
        word[RS2_MSB:RS2_LSB] = REG_IDX_W'(rs2);
        bus_write('0, word);
        model[rd] = alu_model(op, model[rs1], model[rs2]);
    endtask

    task automatic start_test(input string name);
        current_test    = name;
        errors_at_start = error_count;
        test_count++;
    endtask

    task automatic finish_test();
        $display("%-20s %0d errors", current_test, error_count - errors_at_start);
    endtask

    task automatic reset_and_host_rw();
        start_test("reset_and_host_rw");
        for (int i = 0; i < NUM_REGS; i++) check_reg(i);
        for (int i = 0; i < NUM_REGS; i++) write_reg(i, $urandom());
        for (int i = 0; i < NUM_REGS; i++) check_reg(i);
        finish_test();
    endtask

    task automatic each_opcode();
        start_test("each_opcode");
        for (int k = 0; k < 4; k++) begin
            write_reg(1, $urandom());
            write_reg(2, $urandom());
            issue(alu_op_e'(k), 3, 1, 2);
            check_reg(3);  // Read stalls until the result retires
        end
        finish_test();
    endtask

    task automatic dependent_chain();
        start_test("dependent_chain");
        write_reg(1, $urandom());
        write_reg(2, $urandom());
        issue(OP_ADD, 3, 1, 2);
        issue(OP_MUL, 4, 3, 3);
        issue(OP_SUB, 5, 4, 1);
        for (int i = 3; i <= 5; i++) check_reg(i);
        finish_test();
    endtask

    task automatic mul_back_pressure();
        start_test("mul_back_pressure");
        write_reg(1, $urandom());
        write_reg(2, $urandom());
        for (int k = 0; k < 5; k++) issue(OP_MUL, 3 + k, 1, (k % 2) ? 1 : 2);
        for (int k = 0; k < 5; k++) check_reg(3 + k);
        finish_test();
    endtask

    task automatic repeated_rd_rename();
        start_test("repeated_rd_rename");
        write_reg(1, $urandom());
        write_reg(2, $urandom());
        issue(OP_MUL, 6, 1, 2);
        issue(OP_ADD, 7, 6, 1);  // Must see the MUL result
        issue(OP_ADD, 6, 1, 2);  // Younger rename of r6
        check_reg(7);
        check_reg(6);
        finish_test();
    endtask

    initial begin
        reset = 1'b1;
        cyc   = 1'b0;
        stb   = 1'b0;
        we    = 1'b0;
        adr   = '0;
        wdata = '0;
        void'($urandom(55));
        foreach (model[i]) model[i] = '0;
        repeat (4) @(negedge clock);
        reset = 1'b0;
        reset_and_host_rw();
        each_opcode();
        dependent_chain();
        mul_back_pressure();
        repeated_rd_rename();
        $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
rtl/rename_pkg.sv
rtl/map_table.sv
rtl/register_file.sv
rtl/reservation_station.sv
rtl/exec_unit.sv
rtl/issue_control.sv
rtl/rename_core.sv
dv/rename_core_tb.sv

// ==== rtl/exec_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module exec_unit
    import rename_pkg::*;
(
    input  wire logic              clock,
    input  wire logic              reset,
    input  wire logic              disp_valid,
    input  wire alu_op_e           disp_op,
    input  wire logic [DATA_W-1:0] disp_a,
    input  wire logic [DATA_W-1:0] disp_b,
    input  wire logic [TAG_W-1:0]  disp_tag,
    output logic                   exec_ready,
    output logic                   cdb_valid,
    output logic      [TAG_W-1:0]  cdb_tag,
    output logic      [DATA_W-1:0] cdb_value
);

    logic [CNT_W-1:0] count_q;   // Cycles left until broadcast
    logic [TAG_W-1:0] tag_q;
    data_t            result_q;
    data_t            result;
    logic             start;

    // Free again in the broadcast cycle, so one-cycle ops can stream
    assign exec_ready = (count_q <= CNT_W'(1));
    assign start      = disp_valid && exec_ready;

    always_comb begin
        case (disp_op)
            OP_ADD:  result = disp_a + disp_b;
            OP_SUB:  result = disp_a - disp_b;
            OP_AND:  result = disp_a & disp_b;
            OP_MUL:  result = disp_a * disp_b;  // Low half of the product
            default: result = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            count_q <= '0;
        end else if (start) begin
            count_q <= (disp_op == OP_MUL) ? CNT_W'(MUL_LATENCY) : CNT_W'(1);
        end else if (count_q != '0) begin
            count_q <= count_q - CNT_W'(1);
        end
    end

    always_ff @(posedge clock) begin
        if (start) begin
            result_q <= result;
            tag_q    <= disp_tag;
        end
    end

    assign cdb_valid = (count_q == CNT_W'(1));
    assign cdb_tag   = tag_q;
    assign cdb_value = result_q;

endmodule

`default_nettype wire

// ==== rtl/issue_control.sv ====
`timescale 1ns/10ps
`default_nettype none

module issue_control
    import rename_pkg::*;
(
    input  wire logic                 clock,
    input  wire logic                 reset,
    input  wire logic                 cyc,
    input  wire logic                 stb,
    input  wire logic                 we,
    input  wire logic [ADR_W-1:0]     adr,
    input  wire logic [DATA_W-1:0]    wdata,
    input  wire logic                 slot_free,
    input  wire logic                 host_pending,
    output logic                      ack,
    output logic                      issue_valid,
    output alu_op_e                   issue_op,
    output logic      [REG_IDX_W-1:0] issue_rd,
    output logic      [REG_IDX_W-1:0] issue_rs1,
    output logic      [REG_IDX_W-1:0] issue_rs2,
    output logic      [REG_IDX_W-1:0] host_idx,
    output logic                      host_we,
    output logic      [DATA_W-1:0]    host_wdata
);

    ctrl_state_e state_q;
    ctrl_state_e state_d;
    logic        req;

    assign req = cyc && stb;

    // Instruction fields, held stable by the master until ack
    assign issue_op  = alu_op_e'(wdata[OP_MSB:OP_LSB]);
    assign issue_rd  = wdata[RD_MSB:RD_LSB];
    assign issue_rs1 = wdata[RS1_MSB:RS1_LSB];
    assign issue_rs2 = wdata[RS2_MSB:RS2_LSB];

    assign host_idx   = adr[REG_IDX_W-1:0];
    assign host_wdata = wdata;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (req) begin
                    if (adr[REG_SEL_BIT]) begin
                        state_d = REG_WAIT;
                    end else if (we) begin
                        state_d = ISSUE;
                    end else begin
                        state_d = ACK;  // Read of the issue port returns no state
                    end
                end
            end
            ISSUE: begin
                if (!cyc) begin
                    state_d = IDLE;
                end else if (slot_free) begin
                    state_d = ACK;
                end
            end
            REG_WAIT: begin
                if (!cyc) begin
                    state_d = IDLE;
                end else if (!host_pending) begin
                    state_d = ACK;
                end
            end
            ACK:     state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign issue_valid = (state_q == ISSUE) && cyc && slot_free;
    assign host_we     = (state_q == REG_WAIT) && cyc && we && !host_pending;
    assign ack         = (state_q == ACK);

endmodule

`default_nettype wire

// ==== rtl/map_table.sv ====
`timescale 1ns/10ps
`default_nettype none

module map_table
    import rename_pkg::*;
(
    input  wire logic                 clock,
    input  wire logic                 reset,
    input  wire logic                 issue_valid,
    input  wire logic [REG_IDX_W-1:0] issue_rd,
    input  wire logic [TAG_W-1:0]     free_tag,
    input  wire logic [REG_IDX_W-1:0] issue_rs1,
    input  wire logic [REG_IDX_W-1:0] issue_rs2,
    input  wire logic [REG_IDX_W-1:0] host_idx,
    input  wire logic                 cdb_valid,
    input  wire logic [TAG_W-1:0]     cdb_tag,
    output tag_t                      rs1_tag,
    output tag_t                      rs2_tag,
    output logic                      host_pending,
    output logic [REG_IDX_W:0]        cdb_rd_match  // {hit, register index}
);

    tag_t                map_q [NUM_REGS];
    logic [NUM_REGS-1:0] tag_hit;

    // Source lookups see the table before this cycle's update
    assign rs1_tag      = map_q[issue_rs1];
    assign rs2_tag      = map_q[issue_rs2];
    assign host_pending = map_q[host_idx].valid;

    always_comb begin
        for (int i = 0; i < NUM_REGS; i++) begin
            tag_hit[i] = map_q[i].valid && (map_q[i].tag == cdb_tag);
        end
    end

    // At most one entry holds a given tag
    always_comb begin
        cdb_rd_match = '0;
        for (int i = NUM_REGS - 1; i >= 0; i--) begin
            if (tag_hit[i]) begin
                cdb_rd_match = {1'b1, REG_IDX_W'(i)};
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                map_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_REGS; i++) begin
                if (issue_valid && (issue_rd == REG_IDX_W'(i))) begin
                    map_q[i] <= '{valid: 1'b1, tag: free_tag};  // Issue wins over clear
                end else if (cdb_valid && tag_hit[i]) begin
                    map_q[i].valid <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/register_file.sv ====
`timescale 1ns/10ps
`default_nettype none

module register_file
    import rename_pkg::*;
(
    input  wire logic                 clock,
    input  wire logic                 reset,
    input  wire logic [REG_IDX_W-1:0] issue_rs1,
    input  wire logic [REG_IDX_W-1:0] issue_rs2,
    input  wire logic [REG_IDX_W-1:0] host_idx,
    input  wire logic                 host_we,
    input  wire logic [DATA_W-1:0]    host_wdata,
    input  wire logic                 cdb_valid,
    input  wire logic [DATA_W-1:0]    cdb_value,
    input  wire logic [REG_IDX_W:0]   cdb_rd,      // {hit, register index}
    output logic      [DATA_W-1:0]    rs1_value,
    output logic      [DATA_W-1:0]    rs2_value,
    output logic      [DATA_W-1:0]    host_value
);

    data_t regs_q [NUM_REGS];

    assign rs1_value  = regs_q[issue_rs1];
    assign rs2_value  = regs_q[issue_rs2];
    assign host_value = regs_q[host_idx];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else begin
            if (cdb_valid && cdb_rd[REG_IDX_W]) begin
                regs_q[cdb_rd[REG_IDX_W-1:0]] <= cdb_value;  // Retire latest rename only
            end
            if (host_we) begin
                regs_q[host_idx] <= host_wdata;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/rename_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module rename_core
    import rename_pkg::*;
(
    input  wire logic              clock,
    input  wire logic              reset,
    input  wire logic              cyc,
    input  wire logic              stb,
    input  wire logic              we,
    input  wire logic [ADR_W-1:0]  adr,
    input  wire logic [DATA_W-1:0] wdata,
    output logic      [DATA_W-1:0] rdata,
    output logic                   ack
);

    logic                 issue_valid;
    alu_op_e              issue_op;
    logic [REG_IDX_W-1:0] issue_rd;
    logic [REG_IDX_W-1:0] issue_rs1;
    logic [REG_IDX_W-1:0] issue_rs2;
    logic                 slot_free;
    logic [TAG_W-1:0]     free_tag;

    logic [REG_IDX_W-1:0] host_idx;
    logic                 host_we;
    logic [DATA_W-1:0]    host_wdata;
    logic                 host_pending;

    tag_t                 rs1_tag;
    tag_t                 rs2_tag;
    logic [DATA_W-1:0]    rs1_value;
    logic [DATA_W-1:0]    rs2_value;

    logic                 disp_valid;
    alu_op_e              disp_op;
    logic [DATA_W-1:0]    disp_a;
    logic [DATA_W-1:0]    disp_b;
    logic [TAG_W-1:0]     disp_tag;
    logic                 exec_ready;

    logic                 cdb_valid;
    logic [TAG_W-1:0]     cdb_tag;
    logic [DATA_W-1:0]    cdb_value;
    logic [REG_IDX_W:0]   cdb_rd_match;

    issue_control u_issue_control (
        .clock, .reset, .cyc, .stb, .we, .adr, .wdata,
        .slot_free, .host_pending, .ack,
        .issue_valid, .issue_op, .issue_rd, .issue_rs1, .issue_rs2,
        .host_idx, .host_we, .host_wdata
    );

    map_table u_map_table (
        .clock, .reset, .issue_valid, .issue_rd, .free_tag,
        .issue_rs1, .issue_rs2, .host_idx, .cdb_valid, .cdb_tag,
        .rs1_tag, .rs2_tag, .host_pending, .cdb_rd_match
    );

    register_file u_register_file (
        .clock, .reset, .issue_rs1, .issue_rs2,
        .host_idx, .host_we, .host_wdata,
        .cdb_valid, .cdb_value,
        .cdb_rd     (cdb_rd_match),
        .rs1_value, .rs2_value,
        .host_value (rdata)           // Host read data
    );

    reservation_station u_reservation_station (
        .clock, .reset, .issue_valid, .issue_op,
        .rs1_tag, .rs2_tag, .rs1_value, .rs2_value,
        .exec_ready, .cdb_valid, .cdb_tag, .cdb_value,
        .slot_free, .free_tag,
        .disp_valid, .disp_op, .disp_a, .disp_b, .disp_tag
    );

    exec_unit u_exec_unit (
        .clock, .reset, .disp_valid, .disp_op, .disp_a, .disp_b, .disp_tag,
        .exec_ready, .cdb_valid, .cdb_tag, .cdb_value
    );

endmodule

`default_nettype wire

// ==== rtl/rename_pkg.sv ====
`default_nettype none

package rename_pkg;

    localparam int DATA_W      = 32;
    localparam int NUM_REGS    = 8;
    localparam int REG_IDX_W   = 3;
    localparam int NUM_RS      = 4;
    localparam int TAG_W       = 2;
    localparam int MUL_LATENCY = 4;
    localparam int CNT_W       = 3;   // Holds 0..MUL_LATENCY
    localparam int ADR_W       = 4;

    // Wishbone address decode
    localparam int REG_SEL_BIT = 3;   // Set selects a register access

    // Instruction word layout
    localparam int OP_MSB  = 17;
    localparam int OP_LSB  = 16;
    localparam int RD_MSB  = 10;
    localparam int RD_LSB  = 8;
    localparam int RS1_MSB = 6;
    localparam int RS1_LSB = 4;
    localparam int RS2_MSB = 2;
    localparam int RS2_LSB = 0;

    typedef logic [DATA_W-1:0] data_t;

    typedef struct packed {
        logic             valid;  // Value pending from this tag
        logic [TAG_W-1:0] tag;    // Station slot number
    } tag_t;

    typedef enum logic [1:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_MUL
    } alu_op_e;

    typedef enum logic [1:0] {
        IDLE,
        ISSUE,
        REG_WAIT,
        ACK
    } ctrl_state_e;

endpackage

`default_nettype wire

// ==== rtl/reservation_station.sv ====
`timescale 1ns/10ps
`default_nettype none

module reservation_station
    import rename_pkg::*;
(
    input  wire logic              clock,
    input  wire logic              reset,
    input  wire logic              issue_valid,
    input  wire alu_op_e           issue_op,
    input  wire tag_t              rs1_tag,
    input  wire tag_t              rs2_tag,
    input  wire logic [DATA_W-1:0] rs1_value,
    input  wire logic [DATA_W-1:0] rs2_value,
    input  wire logic              exec_ready,
    input  wire logic              cdb_valid,
    input  wire logic [TAG_W-1:0]  cdb_tag,
    input  wire logic [DATA_W-1:0] cdb_value,
    output logic                   slot_free,
    output logic      [TAG_W-1:0]  free_tag,
    output logic                   disp_valid,
    output alu_op_e                disp_op,
    output logic      [DATA_W-1:0] disp_a,
    output logic      [DATA_W-1:0] disp_b,
    output logic      [TAG_W-1:0]  disp_tag
);

    logic    [NUM_RS-1:0] busy_q;
    logic    [NUM_RS-1:0] inflight_q;  // Dispatched, result not yet broadcast
    alu_op_e              op_q    [NUM_RS];
    data_t                a_q     [NUM_RS];
    data_t                b_q     [NUM_RS];
    tag_t                 a_tag_q [NUM_RS];
    tag_t                 b_tag_q [NUM_RS];
    logic    [NUM_RS-1:0] ready;
    logic                 dispatch;
    logic                 rs1_fwd;
    logic                 rs2_fwd;

    assign rs1_fwd = rs1_tag.valid && cdb_valid && (rs1_tag.tag == cdb_tag);
    assign rs2_fwd = rs2_tag.valid && cdb_valid && (rs2_tag.tag == cdb_tag);

    // A tag is reused only after its result has left the bus
    always_comb begin
        slot_free = 1'b0;
        free_tag  = '0;
        for (int i = NUM_RS - 1; i >= 0; i--) begin
            if (!busy_q[i] && !inflight_q[i]) begin
                slot_free = 1'b1;
                free_tag  = TAG_W'(i);
            end
        end
    end

    always_comb begin
        disp_valid = 1'b0;
        disp_tag   = '0;
        for (int i = NUM_RS - 1; i >= 0; i--) begin
            ready[i] = busy_q[i] && !a_tag_q[i].valid && !b_tag_q[i].valid;
            if (ready[i]) begin
                disp_valid = 1'b1;
                disp_tag   = TAG_W'(i);  // Lowest ready slot
            end
        end
    end

    assign disp_op  = op_q[disp_tag];
    assign disp_a   = a_q[disp_tag];
    assign disp_b   = b_q[disp_tag];
    assign dispatch = disp_valid && exec_ready;

    always_ff @(posedge clock) begin
        if (reset) begin
            busy_q     <= '0;
            inflight_q <= '0;
        end else begin
            if (cdb_valid) begin
                inflight_q[cdb_tag] <= 1'b0;
            end
            if (dispatch) begin
                busy_q[disp_tag]     <= 1'b0;
                inflight_q[disp_tag] <= 1'b1;
            end
            if (issue_valid) begin
                busy_q[free_tag] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < NUM_RS; i++) begin
            if (busy_q[i] && cdb_valid && a_tag_q[i].valid && (a_tag_q[i].tag == cdb_tag)) begin
                a_q[i]           <= cdb_value;
                a_tag_q[i].valid <= 1'b0;
            end
            if (busy_q[i] && cdb_valid && b_tag_q[i].valid && (b_tag_q[i].tag == cdb_tag)) begin
                b_q[i]           <= cdb_value;
                b_tag_q[i].valid <= 1'b0;
            end
        end
        if (issue_valid) begin
            op_q[free_tag]    <= issue_op;
            a_q[free_tag]     <= rs1_fwd ? cdb_value : rs1_value;
            b_q[free_tag]     <= rs2_fwd ? cdb_value : rs2_value;
            a_tag_q[free_tag] <= '{valid: rs1_tag.valid && !rs1_fwd, tag: rs1_tag.tag};
            b_tag_q[free_tag] <= '{valid: rs2_tag.valid && !rs2_fwd, tag: rs2_tag.tag};
        end
    end

endmodule

`default_nettype wire
